//--- fma_defines.svh
`ifndef FMA_DEFINES_SVH
`define FMA_DEFINES_SVH

// tagged word fields
`define FMA_EXP_W   8
`define FMA_FRAC_W  23
`define FMA_EXC_W   2
`define FMA_BIAS    127

// tag, sign, exponent and fraction side by side
`define FMA_WORD_W  (`FMA_EXC_W + 1 + `FMA_EXP_W + `FMA_FRAC_W)

// full product of two 1.f significands
`define FMA_PROD_W  (2 * (`FMA_FRAC_W + 1))

// product width plus guard room below it for the aligned addend
`define FMA_SUM_W   (`FMA_PROD_W + `FMA_FRAC_W + 5)

// working exponent with sign and overflow headroom
`define FMA_EREF_W  (`FMA_EXP_W + 2)

`endif

//--- fma_pkg.sv
`include "fma_defines.svh"

package fma_pkg;

	typedef enum logic [`FMA_EXC_W-1:0] {
		EXC_ZERO   = 2'd0,
		EXC_NORMAL = 2'd1,
		EXC_INF    = 2'd2,
		EXC_NAN    = 2'd3
	} exc_e;

	typedef struct packed {
		exc_e                   exc;
		logic                   sign;
		logic [`FMA_EXP_W-1:0]  exp;
		logic [`FMA_FRAC_W-1:0] frac;
	} fp_fields_s;

	// one word, read whole or by field
	typedef union packed {
		logic [`FMA_WORD_W-1:0] raw;
		fp_fields_s             f;
	} fp_word_u;

	typedef struct packed {
		logic     bypass;
		fp_word_u word;
	} special_s;

	// rounded result before packing, with range flags
	typedef struct packed {
		logic                   sign;
		logic [`FMA_EXP_W-1:0]  exp;
		logic [`FMA_FRAC_W-1:0] frac;
		logic                   zero;
		logic                   ovf;
		logic                   unf;
	} norm_res_s;

	// canonical zero, infinity and quiet NaN
	function automatic fp_word_u pack_special(input exc_e exc, input logic sign);
		fp_word_u w;
		w.f.exc  = exc;
		w.f.sign = (exc == EXC_NAN) ? 1'b0 : sign;
		w.f.exp  = (exc == EXC_ZERO) ? '0 : '1;
		w.f.frac = '0;
		w.f.frac[`FMA_FRAC_W-1] = (exc == EXC_NAN);
		return w;
	endfunction

endpackage

//--- fma_stage_if.sv
`timescale 1ns/1ps
`include "fma_defines.svh"

interface fma_stage_if;

	// handshake
	logic                          valid;
	logic                          ready;

	// aligned significands, big one unshifted
	logic [`FMA_SUM_W-1:0]         mant_big;
	logic [`FMA_SUM_W-1:0]         mant_small_aligned;
	logic                          sticky;

	// exponent of the big operand in the product frame
	logic signed [`FMA_EREF_W-1:0] exp_ref;
	logic                          sign_big;
	logic                          eff_sub;

	fma_pkg::special_s             special;

	modport producer (
		output valid,
		output mant_big,
		output mant_small_aligned,
		output sticky,
		output exp_ref,
		output sign_big,
		output eff_sub,
		output special,
		input  ready
	);

	modport consumer (
		input  valid,
		input  mant_big,
		input  mant_small_aligned,
		input  sticky,
		input  exp_ref,
		input  sign_big,
		input  eff_sub,
		input  special,
		output ready
	);

endinterface

//--- fma_special_cases.sv
`timescale 1ns/1ps

module fma_special_cases (
	input  fma_pkg::exc_e     exc_a_i,
	input  fma_pkg::exc_e     exc_b_i,
	input  fma_pkg::exc_e     exc_c_i,
	input  logic              sign_a_i,
	input  logic              sign_b_i,
	input  logic              sign_c_i,
	input  logic              sub_i,
	input  fma_pkg::fp_word_u c_i,
	output fma_pkg::special_s special_o
);

	logic prod_sign;
	logic any_nan;
	logic prod_inf;
	logic prod_zero;
	logic c_inf;
	logic make_nan;

	// sign of the product term as it enters the sum
	assign prod_sign = sign_a_i ^ sign_b_i ^ sub_i;

	assign any_nan = (exc_a_i == fma_pkg::EXC_NAN) || (exc_b_i == fma_pkg::EXC_NAN) ||
		(exc_c_i == fma_pkg::EXC_NAN);
	assign prod_inf = (exc_a_i == fma_pkg::EXC_INF) || (exc_b_i == fma_pkg::EXC_INF);
	assign prod_zero = (exc_a_i == fma_pkg::EXC_ZERO) || (exc_b_i == fma_pkg::EXC_ZERO);
	assign c_inf = (exc_c_i == fma_pkg::EXC_INF);

	// inf times zero, or opposite infinities meeting in the sum
	assign make_nan = any_nan || (prod_inf && prod_zero) ||
		(prod_inf && c_inf && (prod_sign != sign_c_i));

	always_comb begin
		special_o.bypass = 1'b1;
		special_o.word   = '0;
		if (make_nan) begin
			special_o.word = fma_pkg::pack_special(fma_pkg::EXC_NAN, 1'b0);
		end else if (prod_inf) begin
			special_o.word = fma_pkg::pack_special(fma_pkg::EXC_INF, prod_sign);
		end else if (c_inf) begin
			special_o.word = fma_pkg::pack_special(fma_pkg::EXC_INF, sign_c_i);
		end else if (prod_zero) begin
			// product vanishes, c goes out as it came in
			special_o.word = c_i;
		end else begin
			special_o.bypass = 1'b0;
		end
	end

endmodule

//--- fma_lzc.sv
`timescale 1ns/1ps
`include "fma_defines.svh"

module fma_lzc #(
	parameter int  WIDTH = `FMA_SUM_W + 1,
	localparam int CNT_W = $clog2(WIDTH)
) (
	input  logic [WIDTH-1:0] value_i,
	output logic [CNT_W-1:0] count_o,
	output logic             all_zero_o
);

	localparam int PAD = 1 << CNT_W;

	logic [PAD-1:0]   padded;
	logic             vld [CNT_W+1][PAD];
	logic [CNT_W-1:0] cnt [CNT_W+1][PAD];

	// ones below the value keep the padding out of the count
	always_comb begin
		padded = '1;
		padded[PAD-1 -: WIDTH] = value_i;
	end

	// leaves, node 0 holds the msb
	for (genvar i = 0; i < PAD; i++) begin : g_leaf
		assign vld[0][i] = padded[PAD-1-i];
		assign cnt[0][i] = '0;
	end

	// upper half wins whenever it holds a one
	for (genvar l = 1; l <= CNT_W; l++) begin : g_level
		for (genvar n = 0; n < (PAD >> l); n++) begin : g_node
			assign vld[l][n] = vld[l-1][2*n] | vld[l-1][2*n+1];
			assign cnt[l][n] = vld[l-1][2*n] ? cnt[l-1][2*n] :
				cnt[l-1][2*n+1] + CNT_W'(1 << (l - 1));
		end
	end

	assign count_o    = cnt[CNT_W][0];
	assign all_zero_o = ~|value_i;

endmodule

//--- fma_product_align.sv
`timescale 1ns/1ps
`include "fma_defines.svh"

module fma_product_align (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  fma_pkg::fp_word_u a_i,
	input  fma_pkg::fp_word_u b_i,
	input  fma_pkg::fp_word_u c_i,
	input  logic              sub_i,
	input  logic              valid_i,
	output logic              ready_o,
	fma_stage_if.producer     stage_o
);

	localparam int SUM_W = `FMA_SUM_W;
	localparam int SIG_W = `FMA_FRAC_W + 1;
	localparam int EW    = `FMA_EREF_W;
	localparam int SH_W  = $clog2(SUM_W + 1);

	logic [SIG_W-1:0]        sig_a;
	logic [SIG_W-1:0]        sig_b;
	logic [SIG_W-1:0]        sig_c;
	logic [`FMA_PROD_W-1:0]  prod;
	logic signed [EW-1:0]    exp_prod;
	logic signed [EW-1:0]    exp_c;
	logic signed [EW-1:0]    exp_diff;
	logic                    prod_sign;
	logic                    c_zero;
	logic                    c_big;
	logic [SUM_W-1:0]        prod_field;
	logic [SUM_W-1:0]        c_field;
	logic [SUM_W-1:0]        big_field;
	logic [SUM_W-1:0]        small_field;
	logic [SH_W-1:0]         shamt;
	logic [2*SUM_W-1:0]      shifted;
	fma_pkg::special_s       special;

	//////////////////////////////////////////////////////////////////////
	// unpack and multiply
	//////////////////////////////////////////////////////////////////////

	// hidden one only on normal operands, a zero c adds nothing
	assign sig_a = {a_i.f.exc == fma_pkg::EXC_NORMAL, a_i.f.frac};
	assign sig_b = {b_i.f.exc == fma_pkg::EXC_NORMAL, b_i.f.frac};
	assign sig_c = {c_i.f.exc == fma_pkg::EXC_NORMAL, c_i.f.frac};

	assign prod = sig_a * sig_b;

	// product is 2.46 fixed point, so its exponent is ea + eb - bias
	assign exp_prod = EW'(a_i.f.exp) + EW'(b_i.f.exp) - EW'(`FMA_BIAS);
	assign exp_c    = EW'(c_i.f.exp);

	assign prod_sign = a_i.f.sign ^ b_i.f.sign ^ sub_i;
	assign c_zero    = (c_i.f.exc == fma_pkg::EXC_ZERO);

	//////////////////////////////////////////////////////////////////////
	// exponent compare, swap and right alignment
	//////////////////////////////////////////////////////////////////////

	// a zero c never sets the reference exponent
	assign c_big    = !c_zero && (exp_c > exp_prod);
	assign exp_diff = c_big ? (exp_c - exp_prod) : (exp_prod - exp_c);

	// both fields put the 2^0 bit at SUM_W-2
	assign prod_field = {prod, {(SUM_W - `FMA_PROD_W){1'b0}}};
	assign c_field    = {1'b0, sig_c, {(SUM_W - SIG_W - 1){1'b0}}};

	assign big_field   = c_big ? c_field : prod_field;
	assign small_field = c_big ? prod_field : c_field;

	// shifts past the field leave only sticky
	assign shamt = (exp_diff < 0 || exp_diff >= SUM_W) ? SH_W'(SUM_W) :
		exp_diff[SH_W-1:0];

	// lower half collects the bits that fall off the field
	assign shifted = {small_field, {SUM_W{1'b0}}} >> shamt;

	fma_special_cases u_special_cases (
		.exc_a_i   (a_i.f.exc),
		.exc_b_i   (b_i.f.exc),
		.exc_c_i   (c_i.f.exc),
		.sign_a_i  (a_i.f.sign),
		.sign_b_i  (b_i.f.sign),
		.sign_c_i  (c_i.f.sign),
		.sub_i     (sub_i),
		.c_i       (c_i),
		.special_o (special)
	);

	//////////////////////////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////////////////////////

	assign ready_o = stage_o.ready || !stage_o.valid;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stage_o.valid <= 1'b0;
		end else if (ready_o) begin
			stage_o.valid <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i && ready_o) begin
			stage_o.mant_big           <= big_field;
			stage_o.mant_small_aligned <= shifted[2*SUM_W-1 -: SUM_W];
			stage_o.sticky             <= |shifted[SUM_W-1:0];
			stage_o.exp_ref            <= c_big ? exp_c : exp_prod;
			stage_o.sign_big           <= c_big ? c_i.f.sign : prod_sign;
			stage_o.eff_sub            <= prod_sign ^ c_i.f.sign;
			stage_o.special            <= special;
		end
	end

endmodule

//--- fma_normalize_round.sv
`timescale 1ns/1ps
`include "fma_defines.svh"

module fma_normalize_round (
	input  logic              clk_i,
	input  logic              rst_n_i,
	fma_stage_if.consumer     stage_i,
	output fma_pkg::fp_word_u result_o,
	output logic              valid_o,
	input  logic              ready_i
);

	localparam int SUM_W = `FMA_SUM_W;
	localparam int SIG_W = `FMA_FRAC_W + 1;
	localparam int EW    = `FMA_EREF_W + 1;
	localparam int CNT_W = $clog2(SUM_W + 1);
	localparam int GRD   = SUM_W - SIG_W;
	localparam logic signed [EW-1:0] EXP_MAX = EW'((1 << `FMA_EXP_W) - 1);

	logic [SUM_W:0]       sum;
	logic [SUM_W:0]       mag;
	logic [SUM_W:0]       norm;
	logic                 neg;
	logic [CNT_W-1:0]     lz;
	logic                 all_zero;
	logic [SIG_W-1:0]     mant;
	logic                 guard;
	logic                 rest;
	logic                 round_up;
	logic [SIG_W:0]       rounded;
	logic signed [EW-1:0] exp_fin;
	fma_pkg::norm_res_s   res;
	fma_pkg::fp_word_u    word_next;

	//////////////////////////////////////////////////////////////////////
	// add or subtract, then magnitude
	//////////////////////////////////////////////////////////////////////

	// sticky borrows one lsb so the dropped tail counts on subtract
	assign sum = stage_i.eff_sub ?
		{1'b0, stage_i.mant_big} - {1'b0, stage_i.mant_small_aligned} -
			{{SUM_W{1'b0}}, stage_i.sticky} :
		{1'b0, stage_i.mant_big} + {1'b0, stage_i.mant_small_aligned};

	// only near-equal exponents can go negative, and sticky is clear then
	assign neg = stage_i.eff_sub && sum[SUM_W];
	assign mag = neg ? -sum : sum;

	fma_lzc #(
		.WIDTH (SUM_W + 1)
	) u_lzc (
		.value_i    (mag),
		.count_o    (lz),
		.all_zero_o (all_zero)
	);

	//////////////////////////////////////////////////////////////////////
	// normalize and round to nearest even
	//////////////////////////////////////////////////////////////////////

	assign norm = mag << lz;

	assign mant     = norm[SUM_W -: SIG_W];
	assign guard    = norm[GRD];
	assign rest     = (|norm[GRD-1:0]) || stage_i.sticky;
	assign round_up = guard && (rest || mant[0]);
	assign rounded  = {1'b0, mant} + {{SIG_W{1'b0}}, round_up};

	// top bit of the sum sits at exp_ref + 2, carry-out adds one more
	assign exp_fin = {stage_i.exp_ref[EW-2], stage_i.exp_ref} + EW'(2) - EW'(lz) +
		EW'(rounded[SIG_W]);

	always_comb begin
		res.sign = stage_i.sign_big ^ neg;
		res.exp  = exp_fin[`FMA_EXP_W-1:0];
		res.frac = rounded[SIG_W] ? rounded[SIG_W-1:1] : rounded[SIG_W-2:0];
		res.zero = all_zero;
		res.ovf  = (exp_fin >= EXP_MAX);
		res.unf  = (exp_fin <= 0);
	end

	// cancellation is +0, out of range flushes or saturates
	always_comb begin
		if (stage_i.special.bypass) begin
			word_next = stage_i.special.word;
		end else if (res.zero) begin
			word_next = fma_pkg::pack_special(fma_pkg::EXC_ZERO, 1'b0);
		end else if (res.ovf) begin
			word_next = fma_pkg::pack_special(fma_pkg::EXC_INF, res.sign);
		end else if (res.unf) begin
			word_next = fma_pkg::pack_special(fma_pkg::EXC_ZERO, res.sign);
		end else begin
			word_next.f.exc  = fma_pkg::EXC_NORMAL;
			word_next.f.sign = res.sign;
			word_next.f.exp  = res.exp;
			word_next.f.frac = res.frac;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	assign stage_i.ready = ready_i || !valid_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else if (stage_i.ready) begin
			valid_o <= stage_i.valid;
		end
	end

	always_ff @(posedge clk_i) begin
		if (stage_i.valid && stage_i.ready) begin
			result_o <= word_next;
		end
	end

endmodule

//--- mul_acc_unit.sv
`timescale 1ns/1ps
`include "fma_defines.svh"

module mul_acc_unit (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic [`FMA_WORD_W-1:0] a_i,
	input  logic [`FMA_WORD_W-1:0] b_i,
	input  logic [`FMA_WORD_W-1:0] c_i,
	input  logic                   sub_i,
	input  logic                   in_valid_i,
	output logic                   in_ready_o,
	output logic [`FMA_WORD_W-1:0] result_o,
	output logic                   out_valid_o,
	input  logic                   out_ready_i
);

	// aligned operation between the two stages
	fma_stage_if stage_if ();

	// stage 1, multiply and align
	fma_product_align u_product_align (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.c_i     (c_i),
		.sub_i   (sub_i),
		.valid_i (in_valid_i),
		.ready_o (in_ready_o),
		.stage_o (stage_if.producer)
	);

	// stage 2, sum, normalize and round
	fma_normalize_round u_normalize_round (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.stage_i  (stage_if.consumer),
		.result_o (result_o),
		.valid_o  (out_valid_o),
		.ready_i  (out_ready_i)
	);

endmodule

//--- fma_tb.sv
`timescale 1ns/1ps
`include "fma_defines.svh"

module fma_tb;

	localparam int MW        = 512;
	localparam int EXP_MAX   = (1 << `FMA_EXP_W) - 1;
	localparam int N_NORMAL  = 300;
	localparam int N_CANCEL  = 150;
	localparam int N_RANGE   = 150;
	localparam int N_SPECIAL = 200;
	localparam int N_MIX     = 400;
	// four cycles per operation plus drain room, doubled
	localparam int TIMEOUT_CYCLES =
		2 * (4 * (N_NORMAL + N_CANCEL + N_RANGE + N_SPECIAL + N_MIX) + 5 * 20);
	localparam logic [`FMA_FRAC_W-1:0] QNAN_FRAC = 1 << (`FMA_FRAC_W - 1);

	logic                   clk_i = 1'b0;
	logic                   rst_n_i;
	logic [`FMA_WORD_W-1:0] a_i, b_i, c_i, result_o;
	logic                   sub_i, in_valid_i, in_ready_o, out_valid_o, out_ready_i;

	integer seed = 32'hd9b54d8e;
	int cycle_cnt = 0;
	int checks = 0, errors = 0, tests = 0, failed = 0;
	int stalls = 0;
	int lat;
	logic took = 1'b0;
	logic lat_mode = 1'b1;
	logic hold_pending = 1'b0;
	string cur_test = "reset";
	fma_pkg::fp_word_u hold_word;
	fma_pkg::fp_word_u exp_q[$];
	int acc_q[$];

	always #10 clk_i = ~clk_i;

	mul_acc_unit uut (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.c_i         (c_i),
		.sub_i       (sub_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.result_o    (result_o),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic fma_pkg::fp_word_u make_word(input fma_pkg::exc_e exc, input logic sign,
		input logic [`FMA_EXP_W-1:0] exp, input logic [`FMA_FRAC_W-1:0] frac);
		fma_pkg::fp_word_u w;
		w.f.exc  = exc;
		w.f.sign = sign;
		w.f.exp  = exp;
		w.f.frac = frac;
		return w;
	endfunction

	function automatic fma_pkg::fp_word_u retag(input fma_pkg::fp_word_u w, input logic [1:0] tag);
		case (tag)
			2'd0: return make_word(fma_pkg::EXC_ZERO, w.f.sign, '0, '0);
			2'd2: return make_word(fma_pkg::EXC_INF, w.f.sign, '1, '0);
			2'd3: return make_word(fma_pkg::EXC_NAN, w.f.sign, '1, QNAN_FRAC);
			default: return w;
		endcase
	endfunction

	function automatic fma_pkg::fp_word_u model_fma(input fma_pkg::fp_word_u a,
		input fma_pkg::fp_word_u b, input fma_pkg::fp_word_u c, input logic sub);
		logic [MW-1:0] pv, cv, mag, keep, rem, half;
		int pe, ce, base, msb, bexp;
		logic psign, rsign, pinf, pzero;
		pinf  = (a.f.exc == fma_pkg::EXC_INF) || (b.f.exc == fma_pkg::EXC_INF);
		pzero = (a.f.exc == fma_pkg::EXC_ZERO) || (b.f.exc == fma_pkg::EXC_ZERO);
		psign = a.f.sign ^ b.f.sign ^ sub;
		if (a.f.exc == fma_pkg::EXC_NAN || b.f.exc == fma_pkg::EXC_NAN ||
			c.f.exc == fma_pkg::EXC_NAN || (pinf && pzero) ||
			(pinf && c.f.exc == fma_pkg::EXC_INF && psign != c.f.sign))
			return make_word(fma_pkg::EXC_NAN, 1'b0, '1, QNAN_FRAC);
		if (pinf)
			return make_word(fma_pkg::EXC_INF, psign, '1, '0);
		if (c.f.exc == fma_pkg::EXC_INF)
			return make_word(fma_pkg::EXC_INF, c.f.sign, '1, '0);
		if (pzero)
			return c;
		// exact operands as integers over a shared lsb
		pv = {1'b1, a.f.frac} * {1'b1, b.f.frac};
		cv = {1'b1, c.f.frac};
		if (c.f.exc == fma_pkg::EXC_ZERO)
			cv = '0;
		pe = int'(a.f.exp) + int'(b.f.exp) - 2 * (`FMA_BIAS + `FMA_FRAC_W);
		ce = int'(c.f.exp) - `FMA_BIAS - `FMA_FRAC_W;
		base = (pe < ce) ? pe : ce;
		pv = pv << (pe - base);
		cv = cv << (ce - base);
		rsign = psign;
		if (psign == c.f.sign) begin
			mag = pv + cv;
		end else if (pv >= cv) begin
			mag = pv - cv;
		end else begin
			mag = cv - pv;
			rsign = c.f.sign;
		end
		if (mag == '0)
			return make_word(fma_pkg::EXC_ZERO, 1'b0, '0, '0);
		msb = 0;
		for (int i = 0; i < MW; i++) begin
			if (mag[i])
				msb = i;
		end
		bexp = msb + base + `FMA_BIAS;
		// keep 24 bits, nearest even on the rest
		if (msb > `FMA_FRAC_W) begin
			keep = mag >> (msb - `FMA_FRAC_W);
			rem  = mag - (keep << (msb - `FMA_FRAC_W));
			half = MW'(1) << (msb - `FMA_FRAC_W - 1);
			if (rem > half || (rem == half && keep[0]))
				keep = keep + 1'b1;
		end else begin
			keep = mag << (`FMA_FRAC_W - msb);
		end
		if (keep[`FMA_FRAC_W+1]) begin
			keep = keep >> 1;
			bexp++;
		end
		if (bexp >= EXP_MAX)
			return make_word(fma_pkg::EXC_INF, rsign, '1, '0);
		if (bexp <= 0)
			return make_word(fma_pkg::EXC_ZERO, rsign, '0, '0);
		return make_word(fma_pkg::EXC_NORMAL, rsign, bexp[`FMA_EXP_W-1:0],
			keep[`FMA_FRAC_W-1:0]);
	endfunction

	task automatic check_word(input string name, input fma_pkg::fp_word_u expected,
		input fma_pkg::fp_word_u actual);
		checks++;
		if (actual.raw !== expected.raw) begin
			errors++;
			$display("ERROR %s: expected %h actual %h", name, expected.raw, actual.raw);
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("ERROR %s cycles: expected %0d actual %0d", name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// kind 0 normal, 1 near cancel, 2 range, 3 tags, 4 any of them
	task automatic gen_operands(input int kind);
		logic [31:0] r1, r2, r3, r4;
		fma_pkg::fp_word_u a, b, c, zero;
		int ec;
		logic sub;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		r4 = $random(seed);
		zero = make_word(fma_pkg::EXC_ZERO, 1'b0, '0, '0);
		a = make_word(fma_pkg::EXC_NORMAL, r1[31], 8'd100 + r1[4:0], r1[27:5]);
		b = make_word(fma_pkg::EXC_NORMAL, r2[31], 8'd100 + r2[4:0], r2[27:5]);
		// c lands within 32 binades of the product
		ec = int'(a.f.exp) + int'(b.f.exp) - `FMA_BIAS + int'(r3[5:0]) - 32;
		c = make_word(fma_pkg::EXC_NORMAL, r3[31], ec[`FMA_EXP_W-1:0], r4[22:0]);
		sub = r4[31];
		case ((kind == 4) ? int'(r4[27:26]) : kind)
			1: begin
				c = model_fma(a, b, zero, 1'b0);
				c.f.frac = c.f.frac ^ r4[3:0];
				c.f.sign = c.f.sign ^ r4[30];
				sub = !r4[30];
			end
			2: begin
				case (r4[29:28])
					2'd0: begin
						// short significands, a*b exact and cancels to zero
						a.f.frac = {r1[6:0], 16'b0};
						b.f.frac = {r2[6:0], 16'b0};
						c = model_fma(a, b, zero, 1'b0);
						sub = 1'b1;
					end
					2'd1: begin
						a.f.exp = 8'd200 + r1[4:0];
						b.f.exp = 8'd200 + r2[4:0];
					end
					2'd2: begin
						a.f.exp = 8'd1 + r1[5:0];
						b.f.exp = 8'd1 + r2[5:0];
						c = zero;
					end
					default: begin
						// straddles the top exponent
						a.f.exp = 8'd180 + r1[3:0];
						b.f.exp = 8'd190 + r2[3:0];
						c = zero;
					end
				endcase
			end
			3: begin
				a = retag(a, r1[29:28]);
				b = retag(b, r2[29:28]);
				c = retag(c, r3[29:28]);
			end
			default: ;
		endcase
		a_i = a.raw;
		b_i = b.raw;
		c_i = c.raw;
		sub_i = sub;
	endtask

	task automatic run_test(input string name, input int kind, input int count,
		input logic back_pressure);
		int issued;
		int err0;
		logic [31:0] r;
		issued = 0;
		err0 = errors;
		cur_test = name;
		lat_mode = !back_pressure;
		stalls = 0;
		while (issued < count || in_valid_i || exp_q.size() > 0) begin
			@(negedge clk_i);
			r = $random(seed);
			if (in_valid_i && took)
				in_valid_i = 1'b0;
			if (!in_valid_i && issued < count && (!back_pressure || r[2:0] != 3'd0)) begin
				gen_operands(kind);
				in_valid_i = 1'b1;
				issued++;
			end
			out_ready_i = back_pressure ? r[4] : 1'b1;
		end
		if (!back_pressure)
			check_latency({name, " stall"}, 0, stalls);
		tests++;
		if (errors != err0)
			failed++;
		$display("test %-12s %0d operations, %0d errors", name, count, errors - err0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitor, scoreboard and timeout
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: %s made no progress after %0d cycles", cur_test, cycle_cnt);
			$display("TEST FAIL");
			$finish;
		end else if (rst_n_i) begin
			// a stalled result holds still
			if (hold_pending && !out_valid_o) begin
				$display("out_valid_o dropped in %s before the result was taken", cur_test);
				errors++;
			end else if (hold_pending) begin
				check_word({cur_test, " hold"}, hold_word, result_o);
			end
			hold_pending = out_valid_o && !out_ready_i;
			hold_word = result_o;
			if (!in_ready_o && exp_q.size() != 2) begin
				$display("in_ready_o low in %s with %0d operations held", cur_test,
					exp_q.size());
				errors++;
			end
			if (out_valid_o && out_ready_i) begin
				if (exp_q.size() == 0) begin
					$display("result in %s with no operation pending", cur_test);
					errors++;
				end else begin
					check_word(cur_test, exp_q.pop_front(), result_o);
					lat = cycle_cnt - acc_q.pop_front();
					if (lat_mode)
						check_latency(cur_test, 2, lat);
				end
			end
			took = in_valid_i && in_ready_o;
			if (took) begin
				exp_q.push_back(model_fma(a_i, b_i, c_i, sub_i));
				acc_q.push_back(cycle_cnt);
			end
			if (in_valid_i && !in_ready_o)
				stalls++;
		end
	end

	initial begin
		rst_n_i = 1'b0;
		a_i = '0;
		b_i = '0;
		c_i = '0;
		sub_i = 1'b0;
		in_valid_i = 1'b0;
		out_ready_i = 1'b0;
		repeat (10) @(negedge clk_i);
		rst_n_i = 1'b1;
		if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
			$display("handshake outputs not idle after reset");
			errors++;
		end
		run_test("normal", 0, N_NORMAL, 1'b0);
		run_test("cancel", 1, N_CANCEL, 1'b0);
		run_test("range", 2, N_RANGE, 1'b0);
		run_test("special", 3, N_SPECIAL, 1'b0);
		run_test("backpressure", 4, N_MIX, 1'b1);
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
fma_pkg.sv
fma_stage_if.sv
fma_special_cases.sv
fma_lzc.sv
fma_product_align.sv
fma_normalize_round.sv
mul_acc_unit.sv
fma_tb.sv
